/* design/pmu_pkg.sv */
// Register group and bus state enums, configuration bit positions, default sizes
package pmu_pkg;

    // ----------------------------------------
    // Enumerations
    // ----------------------------------------

    // Register group selected by a bus word address
    typedef enum logic [3:0] {
        REG_CFG,
        REG_COUNTER,
        REG_OVF_MASK,
        REG_OVF_VECT,
        REG_MCCU_CFG,
        REG_MCCU_LIMIT,
        REG_MCCU_QUOTA,
        REG_MCCU_WEIGHT,
        REG_NONE
    } reg_group_e;

    // Wishbone slave states
    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_e;

    // ----------------------------------------
    // Configuration bits
    // ----------------------------------------

    // Shared by global and MCCU config registers
    localparam int CFG_EN_BIT      = 0;
    localparam int CFG_SOFTRST_BIT = 1;
    // Core 0 quota update bit in MCCU config
    localparam int MCCU_UPDATE_LSB = 2;

    // Default sizes for the top level
    localparam int DEF_REG_WIDTH    = 32;
    localparam int DEF_N_COUNTERS   = 9;
    localparam int DEF_N_CORES      = 4;
    localparam int DEF_N_EVENTS     = 2;
    localparam int DEF_WEIGHT_WIDTH = 8;

endpackage

/* design/pmu_reg_decode.sv */
// Wishbone classic slave, address decode, configuration, mask, limit and weight registers
module pmu_reg_decode #(
    parameter int REG_WIDTH    = 32,
    parameter int N_COUNTERS   = 9,
    parameter int N_CORES      = 4,
    parameter int N_EVENTS     = 2,
    parameter int WEIGHT_WIDTH = 8
) (
    input  logic                                      clk_i,
    input  logic                                      rstn_i,
    input  logic                                      wb_cyc_i,
    input  logic                                      wb_stb_i,
    input  logic                                      wb_we_i,
    input  logic [REG_WIDTH-1:0]                      wb_adr_i,
    input  logic [REG_WIDTH-1:0]                      wb_dat_i,
    output logic                                      wb_ack_o,
    output logic [N_COUNTERS-1:0]                     cnt_wr_en_o,
    output logic [REG_WIDTH-1:0]                      wr_data_o,
    output logic                                      en_o,
    output logic                                      softrst_o,
    output logic [N_COUNTERS-1:0]                     ovf_mask_o,
    output logic                                      vect_clr_o,
    output logic                                      mccu_en_o,
    output logic                                      mccu_softrst_o,
    output logic [N_CORES-1:0]                        update_o,
    output logic [N_CORES*REG_WIDTH-1:0]              limits_o,
    output logic [N_CORES*N_EVENTS*WEIGHT_WIDTH-1:0]  weights_o,
    output pmu_pkg::reg_group_e                       group_o,
    output logic [REG_WIDTH-1:0]                      index_o,
    output logic [REG_WIDTH-1:0]                      cfg_o,
    output logic [REG_WIDTH-1:0]                      mccu_cfg_o
);

    // Word map where packed weights fill whole words
    localparam int W_BITS      = N_CORES * N_EVENTS * WEIGHT_WIDTH;
    localparam int N_WGT_WORDS = (W_BITS - 1) / REG_WIDTH + 1;
    localparam int BASE_CNT    = 1;
    localparam int BASE_MASK   = BASE_CNT + N_COUNTERS;
    localparam int BASE_VECT   = BASE_MASK + 1;
    localparam int BASE_MCFG   = BASE_VECT + 1;
    localparam int BASE_LIMIT  = BASE_MCFG + 1;
    localparam int BASE_QUOTA  = BASE_LIMIT + N_CORES;
    localparam int BASE_WGT    = BASE_QUOTA + N_CORES;
    localparam int END_MAP     = BASE_WGT + N_WGT_WORDS;

    pmu_pkg::wb_state_e             state_q;
    logic                           wr_fire;
    logic [REG_WIDTH-1:0]           cfg_q;
    logic [REG_WIDTH-1:0]           mccu_cfg_q;
    logic [N_COUNTERS-1:0]          mask_q;
    logic [N_CORES*REG_WIDTH-1:0]   limits_q;
    logic [W_BITS-1:0]              weights_q;

    // ----------------------------------------
    // Bus handshake
    // ----------------------------------------

    // Ack one cycle after a strobe seen in idle
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= pmu_pkg::WB_IDLE;
        end else if (state_q == pmu_pkg::WB_IDLE) begin
            if (wb_cyc_i && wb_stb_i) begin
                state_q <= pmu_pkg::WB_ACK;
            end
        end else begin
            state_q <= pmu_pkg::WB_IDLE;
        end
    end

    assign wb_ack_o = (state_q == pmu_pkg::WB_ACK);
    // Writes land on the edge that raises ack
    assign wr_fire  = (state_q == pmu_pkg::WB_IDLE) && wb_cyc_i && wb_stb_i && wb_we_i;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------

    always_comb begin
        group_o = pmu_pkg::REG_NONE;
        index_o = '0;
        if (wb_adr_i == '0) begin
            group_o = pmu_pkg::REG_CFG;
        end else if (wb_adr_i < BASE_MASK) begin
            group_o = pmu_pkg::REG_COUNTER;
            index_o = wb_adr_i - REG_WIDTH'(BASE_CNT);
        end else if (wb_adr_i == BASE_MASK) begin
            group_o = pmu_pkg::REG_OVF_MASK;
        end else if (wb_adr_i == BASE_VECT) begin
            group_o = pmu_pkg::REG_OVF_VECT;
        end else if (wb_adr_i == BASE_MCFG) begin
            group_o = pmu_pkg::REG_MCCU_CFG;
        end else if (wb_adr_i < BASE_QUOTA) begin
            group_o = pmu_pkg::REG_MCCU_LIMIT;
            index_o = wb_adr_i - REG_WIDTH'(BASE_LIMIT);
        end else if (wb_adr_i < BASE_WGT) begin
            group_o = pmu_pkg::REG_MCCU_QUOTA;
            index_o = wb_adr_i - REG_WIDTH'(BASE_QUOTA);
        end else if (wb_adr_i < END_MAP) begin
            group_o = pmu_pkg::REG_MCCU_WEIGHT;
            index_o = wb_adr_i - REG_WIDTH'(BASE_WGT);
        end
    end

    // One-hot counter preload strobe
    always_comb begin
        cnt_wr_en_o = '0;
        if (wr_fire && group_o == pmu_pkg::REG_COUNTER) begin
            cnt_wr_en_o[index_o] = 1'b1;
        end
    end

    assign vect_clr_o = wr_fire && (group_o == pmu_pkg::REG_OVF_VECT);
    assign wr_data_o  = wb_dat_i;

    // ----------------------------------------
    // Software registers
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_q      <= '0;
            mccu_cfg_q <= '0;
            mask_q     <= '0;
            limits_q   <= '0;
            weights_q  <= '0;
        end else if (wr_fire) begin
            case (group_o)
                pmu_pkg::REG_CFG:        cfg_q      <= wb_dat_i;
                pmu_pkg::REG_MCCU_CFG:   mccu_cfg_q <= wb_dat_i;
                pmu_pkg::REG_OVF_MASK:   mask_q     <= wb_dat_i[N_COUNTERS-1:0];
                pmu_pkg::REG_MCCU_LIMIT: limits_q[index_o*REG_WIDTH +: REG_WIDTH] <= wb_dat_i;
                pmu_pkg::REG_MCCU_WEIGHT: begin
                    // Only bits of the addressed word
                    for (int b = 0; b < W_BITS; b++) begin
                        if (b / REG_WIDTH == index_o) begin
                            weights_q[b] <= wb_dat_i[b % REG_WIDTH];
                        end
                    end
                end
                // Counters, vector clear and quotas handled elsewhere
                default: ;
            endcase
        end
    end

    assign cfg_o          = cfg_q;
    assign mccu_cfg_o     = mccu_cfg_q;
    assign en_o           = cfg_q[pmu_pkg::CFG_EN_BIT];
    assign softrst_o      = cfg_q[pmu_pkg::CFG_SOFTRST_BIT];
    assign mccu_en_o      = mccu_cfg_q[pmu_pkg::CFG_EN_BIT];
    assign mccu_softrst_o = mccu_cfg_q[pmu_pkg::CFG_SOFTRST_BIT];
    assign update_o       = mccu_cfg_q[pmu_pkg::MCCU_UPDATE_LSB +: N_CORES];
    assign ovf_mask_o     = mask_q;
    assign limits_o       = limits_q;
    assign weights_o      = weights_q;

endmodule

/* design/pmu_counters.sv */
// Event counter bank with preload, soft reset and per-counter wrap flags
module pmu_counters #(
    parameter int REG_WIDTH  = 32,
    parameter int N_COUNTERS = 9
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            en_i,
    input  logic                            softrst_i,
    input  logic [N_COUNTERS-1:0]           events_i,
    input  logic [N_COUNTERS-1:0]           wr_en_i,
    input  logic [REG_WIDTH-1:0]            wr_data_i,
    output logic [N_COUNTERS*REG_WIDTH-1:0] count_o,
    output logic [N_COUNTERS-1:0]           wrap_o
);

    // ----------------------------------------
    // One counter per event line
    // ----------------------------------------

    for (genvar i = 0; i < N_COUNTERS; i++) begin : g_cnt
        logic [REG_WIDTH-1:0] cnt_q;
        logic                 wrap_q;

        // Soft reset beats preload and preload beats counting
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                cnt_q  <= '0;
                wrap_q <= 1'b0;
            end else if (softrst_i) begin
                cnt_q  <= '0;
                wrap_q <= 1'b0;
            end else if (wr_en_i[i]) begin
                cnt_q  <= wr_data_i;
                wrap_q <= 1'b0;
            end else if (en_i && events_i[i]) begin
                cnt_q  <= cnt_q + 1'b1;
                // All ones rolls over to zero here
                wrap_q <= &cnt_q;
            end else begin
                wrap_q <= 1'b0;
            end
        end

        assign count_o[i*REG_WIDTH +: REG_WIDTH] = cnt_q;
        assign wrap_o[i]                         = wrap_q;
    end

endmodule

/* design/pmu_mccu.sv */
// Per-core weighted contention quota tracking and quota-exhausted interrupts
module pmu_mccu #(
    parameter int REG_WIDTH    = 32,
    parameter int N_CORES      = 4,
    parameter int N_EVENTS     = 2,
    parameter int WEIGHT_WIDTH = 8
) (
    input  logic                                      clk_i,
    input  logic                                      rstn_i,
    input  logic                                      en_i,
    input  logic                                      softrst_i,
    input  logic [N_CORES-1:0]                        update_i,
    input  logic [N_CORES*N_EVENTS-1:0]               events_i,
    input  logic [N_CORES*REG_WIDTH-1:0]              limits_i,
    input  logic [N_CORES*N_EVENTS*WEIGHT_WIDTH-1:0]  weights_i,
    output logic [N_CORES*REG_WIDTH-1:0]              quota_o,
    output logic [N_CORES-1:0]                        intr_mccu_o
);

    // Room for N_EVENTS full-scale weights
    localparam int SUM_WIDTH = WEIGHT_WIDTH + $clog2(N_EVENTS + 1);

    // ----------------------------------------
    // Per-core quota tracking
    // ----------------------------------------

    for (genvar k = 0; k < N_CORES; k++) begin : g_core
        logic [SUM_WIDTH-1:0] sum;
        logic [REG_WIDTH-1:0] sum_ext;
        logic [REG_WIDTH-1:0] quota_q;
        logic                 intr_q;

        // Core k owns events k*N_EVENTS and up
        always_comb begin
            sum = '0;
            for (int e = 0; e < N_EVENTS; e++) begin
                if (events_i[k*N_EVENTS + e]) begin
                    sum = sum + SUM_WIDTH'(weights_i[(k*N_EVENTS + e)*WEIGHT_WIDTH +: WEIGHT_WIDTH]);
                end
            end
        end

        assign sum_ext = REG_WIDTH'(sum);

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                quota_q <= '0;
                intr_q  <= 1'b0;
            end else if (softrst_i) begin
                quota_q <= '0;
                intr_q  <= 1'b0;
            end else if (update_i[k]) begin
                // Reload from software limit
                quota_q <= limits_i[k*REG_WIDTH +: REG_WIDTH];
                intr_q  <= 1'b0;
            end else if (en_i) begin
                if (sum_ext > quota_q) begin
                    // Saturate and flag exhaustion
                    quota_q <= '0;
                    intr_q  <= 1'b1;
                end else begin
                    quota_q <= quota_q - sum_ext;
                end
            end
        end

        assign quota_o[k*REG_WIDTH +: REG_WIDTH] = quota_q;
        // Sticky until the next update
        assign intr_mccu_o[k]                    = intr_q;
    end

endmodule

/* design/pmu_status.sv */
// Sticky overflow vector, masked overflow interrupt and read-data multiplexer
module pmu_status #(
    parameter int REG_WIDTH    = 32,
    parameter int N_COUNTERS   = 9,
    parameter int N_CORES      = 4,
    parameter int N_EVENTS     = 2,
    parameter int WEIGHT_WIDTH = 8
) (
    input  logic                                      clk_i,
    input  logic                                      rstn_i,
    input  logic                                      softrst_i,
    input  logic [N_COUNTERS-1:0]                     wrap_i,
    input  logic [N_COUNTERS-1:0]                     ovf_mask_i,
    input  logic                                      vect_clr_i,
    input  logic [REG_WIDTH-1:0]                      clr_data_i,
    input  pmu_pkg::reg_group_e                       group_i,
    input  logic [REG_WIDTH-1:0]                      index_i,
    input  logic [REG_WIDTH-1:0]                      cfg_i,
    input  logic [REG_WIDTH-1:0]                      mccu_cfg_i,
    input  logic [N_COUNTERS*REG_WIDTH-1:0]           count_i,
    input  logic [N_CORES*REG_WIDTH-1:0]              limits_i,
    input  logic [N_CORES*N_EVENTS*WEIGHT_WIDTH-1:0]  weights_i,
    input  logic [N_CORES*REG_WIDTH-1:0]              quota_i,
    output logic [REG_WIDTH-1:0]                      wb_dat_o,
    output logic                                      intr_overflow_o
);

    logic [N_COUNTERS-1:0]                               vect_q;
    logic [N_COUNTERS-1:0]                               clr_bits;
    // Zero word on top keeps the last weight word in range
    logic [N_CORES*N_EVENTS*WEIGHT_WIDTH+REG_WIDTH-1:0]  weights_pad;

    // ----------------------------------------
    // Overflow vector
    // ----------------------------------------

    assign clr_bits = vect_clr_i ? clr_data_i[N_COUNTERS-1:0] : '0;

    // New wrap wins over a clear in the same cycle
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vect_q <= '0;
        end else if (softrst_i) begin
            vect_q <= '0;
        end else begin
            vect_q <= (vect_q & ~clr_bits) | wrap_i;
        end
    end

    assign intr_overflow_o = |(vect_q & ovf_mask_i);

    // ----------------------------------------
    // Read back
    // ----------------------------------------

    assign weights_pad = {{REG_WIDTH{1'b0}}, weights_i};

    always_comb begin
        case (group_i)
            pmu_pkg::REG_CFG:         wb_dat_o = cfg_i;
            pmu_pkg::REG_COUNTER:     wb_dat_o = count_i[index_i*REG_WIDTH +: REG_WIDTH];
            pmu_pkg::REG_OVF_MASK:    wb_dat_o = REG_WIDTH'(ovf_mask_i);
            pmu_pkg::REG_OVF_VECT:    wb_dat_o = REG_WIDTH'(vect_q);
            pmu_pkg::REG_MCCU_CFG:    wb_dat_o = mccu_cfg_i;
            pmu_pkg::REG_MCCU_LIMIT:  wb_dat_o = limits_i[index_i*REG_WIDTH +: REG_WIDTH];
            pmu_pkg::REG_MCCU_QUOTA:  wb_dat_o = quota_i[index_i*REG_WIDTH +: REG_WIDTH];
            pmu_pkg::REG_MCCU_WEIGHT: wb_dat_o = weights_pad[index_i*REG_WIDTH +: REG_WIDTH];
            // Unmapped words
            default:                  wb_dat_o = '0;
        endcase
    end

endmodule

/* design/pmu_top.sv */
// Top level with parameters, bus decode, counters, MCCU and status wiring
module pmu_top #(
    parameter int REG_WIDTH    = pmu_pkg::DEF_REG_WIDTH,
    parameter int N_COUNTERS   = pmu_pkg::DEF_N_COUNTERS,
    parameter int N_CORES      = pmu_pkg::DEF_N_CORES,
    parameter int N_EVENTS     = pmu_pkg::DEF_N_EVENTS,
    parameter int WEIGHT_WIDTH = pmu_pkg::DEF_WEIGHT_WIDTH
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // Wishbone classic with full-word accesses only
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [REG_WIDTH-1:0]  wb_adr_i,
    input  logic [REG_WIDTH-1:0]  wb_dat_i,
    output logic                  wb_ack_o,
    output logic [REG_WIDTH-1:0]  wb_dat_o,
    input  logic [N_COUNTERS-1:0] events_i,
    output logic                  intr_overflow_o,
    output logic [N_CORES-1:0]    intr_mccu_o
);

    localparam int W_BITS = N_CORES * N_EVENTS * WEIGHT_WIDTH;

    logic [N_COUNTERS-1:0]           cnt_wr_en;
    logic [REG_WIDTH-1:0]            wr_data;
    logic                            en;
    logic                            softrst;
    logic [N_COUNTERS-1:0]           ovf_mask;
    logic                            vect_clr;
    logic                            mccu_en;
    logic                            mccu_softrst;
    logic [N_CORES-1:0]              mccu_update;
    logic [N_CORES*REG_WIDTH-1:0]    limits;
    logic [W_BITS-1:0]               weights;
    pmu_pkg::reg_group_e             group;
    logic [REG_WIDTH-1:0]            index;
    logic [REG_WIDTH-1:0]            cfg;
    logic [REG_WIDTH-1:0]            mccu_cfg;
    logic [N_COUNTERS*REG_WIDTH-1:0] count;
    logic [N_COUNTERS-1:0]           wrap;
    logic [N_CORES*REG_WIDTH-1:0]    quota;

    // ----------------------------------------
    // Decode
    // ----------------------------------------

    pmu_reg_decode #(
        .REG_WIDTH    (REG_WIDTH),
        .N_COUNTERS   (N_COUNTERS),
        .N_CORES      (N_CORES),
        .N_EVENTS     (N_EVENTS),
        .WEIGHT_WIDTH (WEIGHT_WIDTH)
    ) i_pmu_reg_decode (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_o       (wb_ack_o),
        .cnt_wr_en_o    (cnt_wr_en),
        .wr_data_o      (wr_data),
        .en_o           (en),
        .softrst_o      (softrst),
        .ovf_mask_o     (ovf_mask),
        .vect_clr_o     (vect_clr),
        .mccu_en_o      (mccu_en),
        .mccu_softrst_o (mccu_softrst),
        .update_o       (mccu_update),
        .limits_o       (limits),
        .weights_o      (weights),
        .group_o        (group),
        .index_o        (index),
        .cfg_o          (cfg),
        .mccu_cfg_o     (mccu_cfg)
    );

    // ----------------------------------------
    // Execute
    // ----------------------------------------

    pmu_counters #(
        .REG_WIDTH  (REG_WIDTH),
        .N_COUNTERS (N_COUNTERS)
    ) i_pmu_counters (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .en_i      (en),
        .softrst_i (softrst),
        .events_i  (events_i),
        .wr_en_i   (cnt_wr_en),
        .wr_data_i (wr_data),
        .count_o   (count),
        .wrap_o    (wrap)
    );

    // Low event lines feed the MCCU with two per core
    pmu_mccu #(
        .REG_WIDTH    (REG_WIDTH),
        .N_CORES      (N_CORES),
        .N_EVENTS     (N_EVENTS),
        .WEIGHT_WIDTH (WEIGHT_WIDTH)
    ) i_pmu_mccu (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .en_i        (mccu_en),
        .softrst_i   (mccu_softrst),
        .update_i    (mccu_update),
        .events_i    (events_i[N_CORES*N_EVENTS-1:0]),
        .limits_i    (limits),
        .weights_i   (weights),
        .quota_o     (quota),
        .intr_mccu_o (intr_mccu_o)
    );

    // ----------------------------------------
    // Result
    // ----------------------------------------

    pmu_status #(
        .REG_WIDTH    (REG_WIDTH),
        .N_COUNTERS   (N_COUNTERS),
        .N_CORES      (N_CORES),
        .N_EVENTS     (N_EVENTS),
        .WEIGHT_WIDTH (WEIGHT_WIDTH)
    ) i_pmu_status (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .softrst_i       (softrst),
        .wrap_i          (wrap),
        .ovf_mask_i      (ovf_mask),
        .vect_clr_i      (vect_clr),
        .clr_data_i      (wr_data),
        .group_i         (group),
        .index_i         (index),
        .cfg_i           (cfg),
        .mccu_cfg_i      (mccu_cfg),
        .count_i         (count),
        .limits_i        (limits),
        .weights_i       (weights),
        .quota_i         (quota),
        .wb_dat_o        (wb_dat_o),
        .intr_overflow_o (intr_overflow_o)
    );

endmodule

/* sim/pmu_sva.sv */
// Bound assertions on the Wishbone handshake and the PMU interrupt outputs
module pmu_sva #(
    parameter int N_CORES = 4
) (
    input logic               clk_i,
    input logic               rstn_i,
    input logic               cyc_i,
    input logic               stb_i,
    input logic               ack_i,
    input logic               intr_overflow_i,
    input logic [N_CORES-1:0] intr_mccu_i,
    input logic [N_CORES-1:0] update_i,
    input logic               softrst_i
);

    // Failures seen so far for the testbench to watch
    int fail_count = 0;

    // ----------------------------------------
    // Bus handshake
    // ----------------------------------------

    a_ack_after_stb: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ack_i |-> $past(cyc_i && stb_i))
    else begin
        $error("wb_ack_o raised without a preceding strobe");
        fail_count++;
    end

    // Single-cycle ack
    a_ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ack_i |=> !ack_i)
    else begin
        $error("wb_ack_o held longer than one cycle");
        fail_count++;
    end

    // ----------------------------------------
    // Interrupts
    // ----------------------------------------

    a_intr_reset: assert property (@(posedge clk_i)
        !rstn_i |-> (!intr_overflow_i && intr_mccu_i == '0))
    else begin
        $error("interrupt high while reset is asserted");
        fail_count++;
    end

    // Sticky until reload or MCCU soft reset
    for (genvar k = 0; k < N_CORES; k++) begin : g_core
        a_intr_fall: assert property (@(posedge clk_i) disable iff (!rstn_i)
            $fell(intr_mccu_i[k]) |-> $past(update_i[k] || softrst_i))
        else begin
            $error("intr_mccu_o[%0d] fell without a quota update", k);
            fail_count++;
        end
    end

endmodule

bind pmu_top pmu_sva #(
    .N_CORES (N_CORES)
) i_pmu_sva (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .cyc_i           (wb_cyc_i),
    .stb_i           (wb_stb_i),
    .ack_i           (wb_ack_o),
    .intr_overflow_i (intr_overflow_o),
    .intr_mccu_i     (intr_mccu_o),
    .update_i        (mccu_update),
    .softrst_i       (mccu_softrst)
);

/* sim/pmu_tb.sv */
// Testbench with clock, reset, Wishbone tasks, xorshift stimulus, MCCU model and checks
module pmu_tb;

    localparam int N_COUNTERS  = pmu_pkg::DEF_N_COUNTERS;
    localparam int N_CORES     = pmu_pkg::DEF_N_CORES;
    localparam int N_WEIGHTS   = N_CORES * pmu_pkg::DEF_N_EVENTS;
    // Word map
    localparam int ADR_CNT     = 1;
    localparam int ADR_MASK    = ADR_CNT + N_COUNTERS;
    localparam int ADR_VECT    = ADR_MASK + 1;
    localparam int ADR_MCFG    = ADR_VECT + 1;
    localparam int ADR_LIMIT   = ADR_MCFG + 1;
    localparam int ADR_QUOTA   = ADR_LIMIT + N_CORES;
    localparam int ADR_WGT     = ADR_QUOTA + N_CORES;
    localparam int N_WGT_WORDS = N_WEIGHTS / 4;
    localparam int ADR_NONE    = ADR_WGT + N_WGT_WORDS;
    localparam int EN          = 1 << pmu_pkg::CFG_EN_BIT;
    localparam int SOFTRST     = 1 << pmu_pkg::CFG_SOFTRST_BIT;
    localparam int UPDATE_ALL  = ((1 << N_CORES) - 1) << pmu_pkg::MCCU_UPDATE_LSB;
    localparam int MCCU_CYCLES = 600;
    // Tests take about 750 cycles
    localparam int MAX_CYCLES  = 3000;

    logic                  clk_i = 1'b0;
    logic                  rstn_i;
    logic                  wb_cyc_i;
    logic                  wb_stb_i;
    logic                  wb_we_i;
    logic [31:0]           wb_adr_i;
    logic [31:0]           wb_dat_i;
    logic                  wb_ack_o;
    logic [31:0]           wb_dat_o;
    logic [N_COUNTERS-1:0] events_i;
    logic                  intr_overflow_o;
    logic [N_CORES-1:0]    intr_mccu_o;

    int          cycle_count = 0;
    logic [31:0] rng;
    logic [31:0] limit [N_CORES];
    logic [31:0] model_quota [N_CORES];
    logic [N_CORES-1:0] model_intr;
    logic [7:0]  wgt [N_WEIGHTS];

    pmu_top i_pmu_top (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_stb_i        (wb_stb_i),
        .wb_we_i         (wb_we_i),
        .wb_adr_i        (wb_adr_i),
        .wb_dat_i        (wb_dat_i),
        .wb_ack_o        (wb_ack_o),
        .wb_dat_o        (wb_dat_o),
        .events_i        (events_i),
        .intr_overflow_o (intr_overflow_o),
        .intr_mccu_o     (intr_mccu_o)
    );

    always #2 clk_i = ~clk_i;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Weight sum of core k for one event pattern
    function automatic logic [31:0] core_demand(input int k, input logic [N_COUNTERS-1:0] ev);
        logic [31:0] sum;
        sum = 0;
        if (ev[2*k])
            sum = sum + wgt[2*k];
        if (ev[2*k+1])
            sum = sum + wgt[2*k+1];
        return sum;
    endfunction

    task automatic report_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error: time %0t, %s expected 0x%08h, read 0x%08h",
                     $time, name, expected, actual);
            report_failure();
        end
    endtask

    // One classic cycle that returns at the falling edge inside the ack cycle
    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        do
            @(negedge clk_i);
        while (!wb_ack_o);
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic read_check(input string name, input logic [31:0] adr,
                              input logic [31:0] expected);
        logic [31:0] rdata;
        bus_access(1'b0, adr, 32'h0, rdata);
        check_value(name, expected, rdata);
    endtask

    // Event line high for exactly k rising edges
    task automatic hold_event(input int idx, input int k);
        @(negedge clk_i);
        events_i[idx] = 1'b1;
        repeat (k) @(negedge clk_i);
        events_i[idx] = 1'b0;
    endtask

    // ----------------------------------------
    // Watchdogs
    // ----------------------------------------

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            report_failure();
        end
    end

    // Bound checker failures stop the run
    always @(negedge clk_i) begin
        if (i_pmu_top.i_pmu_sva.fail_count != 0) begin
            $display("bound assertion on bus or interrupts failed");
            report_failure();
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        rstn_i   = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        events_i = '0;
        rng      = 32'd67131;
        repeat (3) @(negedge clk_i);
        rstn_i = 1'b1;

        // Reset values
        check_value("intr_overflow_o", 0, intr_overflow_o);
        check_value("intr_mccu_o", 0, intr_mccu_o);
        read_check("cfg", 0, 0);
        for (int i = 0; i < N_COUNTERS; i++)
            read_check($sformatf("counter %0d", i), ADR_CNT + i, 0);
        read_check("overflow vector", ADR_VECT, 0);
        for (int k = 0; k < N_CORES; k++)
            read_check($sformatf("quota %0d", k), ADR_QUOTA + k, 0);

        // Read back of software registers
        bus_write(0, 32'hA5A5_0000);
        read_check("cfg", 0, 32'hA5A5_0000);
        bus_write(ADR_MASK, 32'h155);
        read_check("overflow mask", ADR_MASK, 32'h155);
        bus_write(ADR_MCFG, 32'hFFFF_0000);
        read_check("mccu cfg", ADR_MCFG, 32'hFFFF_0000);
        bus_write(ADR_MCFG, 0);
        read_check("unmapped", ADR_NONE, 0);
        read_check("unmapped", 32'hFFFF_FFFF, 0);

        // Counting, preload and soft reset
        bus_write(0, EN);
        hold_event(3, 5);
        read_check("counter 3", ADR_CNT + 3, 5);
        bus_write(ADR_CNT + 5, 100);
        hold_event(5, 7);
        read_check("counter 5", ADR_CNT + 5, 107);
        bus_write(0, EN | SOFTRST);
        read_check("counter 3", ADR_CNT + 3, 0);
        read_check("counter 5", ADR_CNT + 5, 0);
        bus_write(0, EN);

        // Wrap with mask set, then with mask clear
        bus_write(ADR_MASK, 1 << 6);
        bus_write(ADR_CNT + 6, 32'hFFFF_FFFF);
        hold_event(6, 1);
        read_check("counter 6", ADR_CNT + 6, 0);
        read_check("overflow vector", ADR_VECT, 1 << 6);
        check_value("intr_overflow_o", 1, intr_overflow_o);
        bus_write(ADR_VECT, 1 << 6);
        read_check("overflow vector", ADR_VECT, 0);
        check_value("intr_overflow_o", 0, intr_overflow_o);
        bus_write(ADR_CNT + 7, 32'hFFFF_FFFF);
        hold_event(7, 1);
        read_check("overflow vector", ADR_VECT, 1 << 7);
        check_value("intr_overflow_o", 0, intr_overflow_o);
        bus_write(ADR_VECT, 1 << 7);
        read_check("overflow vector", ADR_VECT, 0);

        // Random limits whose range widens with the core index
        // so low cores run dry and high cores keep some quota
        for (int k = 0; k < N_CORES; k++) begin
            rng = xorshift32(rng);
            limit[k] = rng & ((32'h400 << (4 * k)) - 1);
            bus_write(ADR_LIMIT + k, limit[k]);
            read_check($sformatf("limit %0d", k), ADR_LIMIT + k, limit[k]);
        end
        for (int i = 0; i < N_WEIGHTS; i++) begin
            rng = xorshift32(rng);
            wgt[i] = rng[7:0];
        end
        for (int w = 0; w < N_WGT_WORDS; w++) begin
            bus_write(ADR_WGT + w, {wgt[4*w+3], wgt[4*w+2], wgt[4*w+1], wgt[4*w]});
            read_check($sformatf("weight word %0d", w), ADR_WGT + w,
                       {wgt[4*w+3], wgt[4*w+2], wgt[4*w+1], wgt[4*w]});
        end

        // Load quotas, then release the update bits
        bus_write(ADR_MCFG, EN | UPDATE_ALL);
        bus_write(ADR_MCFG, EN);
        for (int k = 0; k < N_CORES; k++)
            model_quota[k] = limit[k];
        model_intr = '0;

        // Each pattern is consumed by the next rising edge
        for (int c = 0; c < MCCU_CYCLES; c++) begin
            @(negedge clk_i);
            check_value("intr_mccu_o", model_intr, intr_mccu_o);
            rng = xorshift32(rng);
            events_i = rng[N_COUNTERS-1:0];
            for (int k = 0; k < N_CORES; k++) begin
                if (core_demand(k, events_i) > model_quota[k]) begin
                    model_quota[k] = 0;
                    model_intr[k]  = 1'b1;
                end else begin
                    model_quota[k] = model_quota[k] - core_demand(k, events_i);
                end
            end
        end
        @(negedge clk_i);
        events_i = '0;
        check_value("intr_mccu_o", model_intr, intr_mccu_o);
        for (int k = 0; k < N_CORES; k++)
            read_check($sformatf("quota %0d", k), ADR_QUOTA + k, model_quota[k]);

        // Update clears the interrupts and reloads
        bus_write(ADR_MCFG, EN | UPDATE_ALL);
        // First edge with the update bits set clears them
        @(negedge clk_i);
        check_value("intr_mccu_o", 0, intr_mccu_o);
        for (int k = 0; k < N_CORES; k++)
            read_check($sformatf("quota %0d", k), ADR_QUOTA + k, limit[k]);
        bus_write(ADR_MCFG, 0);

        @(negedge clk_i);
        if (i_pmu_top.i_pmu_sva.fail_count != 0) begin
            $display("bound assertion on bus or interrupts failed");
            report_failure();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* verilog.f */
design/pmu_pkg.sv
design/pmu_reg_decode.sv
design/pmu_counters.sv
design/pmu_mccu.sv
design/pmu_status.sv
design/pmu_top.sv
sim/pmu_sva.sv
sim/pmu_tb.sv
